// File: Makefile
# Verilator build and run for the decode stage

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = id_decode_tb
FILELIST = mips_id.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Pass or fail comes from the log, not the exit code
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/id_decode_ref.svh
// Decode reference model
`ifndef ID_DECODE_REF_SVH
`define ID_DECODE_REF_SVH

// Membership test against a space padded name list
function automatic bit listed(string m, string list);
    string key;
    key = {" ", m, " "};
    for (int i = 0; i + key.len() <= list.len(); i++) begin
        if (list.substr(i, i + key.len() - 1) == key) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// Mnemonic of a word, empty when not a kept encoding
function automatic string mnemonic(logic [`MIPS_XLEN-1:0] w);
    mips_id_pkg::opcode_e op;
    mips_id_pkg::funct_e  fn;
    mips_id_pkg::regimm_e ri;
    string n;
    op = mips_id_pkg::opcode_e'(w[31:26]);
    fn = mips_id_pkg::funct_e'(w[5:0]);
    ri = mips_id_pkg::regimm_e'(w[20:16]);
    if (op == mips_id_pkg::OP_SPECIAL) n = fn.name();
    else if (op == mips_id_pkg::OP_REGIMM) n = ri.name();
    else n = op.name();
    // Drop the OP_, FN_ or RI_ prefix
    return (n.len() > 3) ? n.substr(3, n.len() - 1) : "";
endfunction

// ALU code whose name carries the same mnemonic
function automatic mips_id_pkg::alu_op_e op_by_name(string m);
    mips_id_pkg::alu_op_e op;
    op = op.first();
    for (int i = 0; i < op.num(); i++) begin
        if (op.name() == {"ALU_", m}) begin
            return op;
        end
        op = op.next();
    end
    return mips_id_pkg::ALU_NOP;
endfunction

function automatic mips_id_pkg::id_ctrl_t ref_ctrl(logic [`MIPS_XLEN-1:0] w);
    mips_id_pkg::id_ctrl_t c;
    string m;
    bit r_type;
    bit imm_alu;
    bit load;
    bit store;
    c = '0;
    m = mnemonic(w);
    // NOP word and unknowns keep every flag low
    if (w == '0 || m == "") return c;
    r_type  = (w[31:26] == 6'h00);
    imm_alu = listed(m, " ADDI ADDIU SLTI SLTIU ANDI ORI XORI LUI ");
    load    = listed(m, " LB LBU LH LHU LW ");
    store   = listed(m, " SB SH SW ");
    c.alu_src    = imm_alu || load || store;
    c.reg_dst    = r_type;
    c.reg_write  = (r_type && !listed(m, " JR MTHI MTLO SYSCALL BREAK ")) ||
                   imm_alu || load || listed(m, " JAL BGEZAL BLTZAL ");
    c.mem_read   = load;
    c.mem_to_reg = load;
    c.mem_write  = store;
    c.branch     = listed(m, " BEQ BNE BGTZ BLEZ BGEZ BLTZ BGEZAL BLTZAL ");
    c.jump       = listed(m, " J JAL JR JALR ");
    return c;
endfunction

function automatic mips_id_pkg::id_alu_t ref_alu(logic [`MIPS_XLEN-1:0] w);
    mips_id_pkg::id_alu_t a;
    string m;
    m = mnemonic(w);
    a.alu_op  = op_by_name(m);
    a.alu_sel = mips_id_pkg::SEL_NOP;
    if (listed(m, " ADD ADDU SUB SUBU SLT SLTU MULT MULTU DIV DIVU ") ||
        listed(m, " ADDI ADDIU SLTI SLTIU ")) begin
        a.alu_sel = mips_id_pkg::SEL_ARITHMETIC;
    end else if (listed(m, " AND OR XOR NOR ANDI ORI XORI LUI ")) begin
        a.alu_sel = mips_id_pkg::SEL_LOGIC;
    end else if (listed(m, " SLL SRL SRA SLLV SRLV SRAV ")) begin
        a.alu_sel = mips_id_pkg::SEL_SHIFT;
    end else if (listed(m, " MFHI MTHI MFLO MTLO ")) begin
        a.alu_sel = mips_id_pkg::SEL_MOVE;
    end else if (listed(m, " LB LBU LH LHU LW SB SH SW ")) begin
        a.alu_sel = mips_id_pkg::SEL_LOAD_STORE;
    end
    return a;
endfunction

function automatic mips_id_pkg::id_target_t ref_targets(logic [`MIPS_XLEN-1:0] w,
                                                        logic [`MIPS_XLEN-1:0] pc);
    mips_id_pkg::id_target_t t;
    // Zero extension only for the logical immediates
    if (listed(mnemonic(w), " ANDI ORI XORI LUI ")) t.extended_imm = {16'h0000, w[15:0]};
    else t.extended_imm = 32'($signed(w[15:0]));
    t.pc_plus_4 = pc + 32'd4;
    t.pc_branch = t.pc_plus_4 + (t.extended_imm << 2);
    t.pc_jump   = {t.pc_plus_4[31:28], w[25:0], 2'b00};
    return t;
endfunction

`endif

// File: dv/id_decode_tb.sv
// Decode stage testbench
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_decode_tb;

    localparam int        CLK_PERIOD   = 8;
    localparam int        RESET_CYCLES = 3;
    localparam bit [31:0] SEED         = 32'h493475b7;

    // Stimulus cycles per test
    localparam int N_RESET     = RESET_CYCLES + 1;
    localparam int N_KEPT      = 28 + 4 + 22 * 4;
    localparam int N_UNKNOWN   = 1 + 64 + 64 + 32;
    localparam int N_STALL     = 200;
    localparam int N_RANDOM    = 2000;
    localparam int N_TOTAL     = N_RESET + N_KEPT + N_UNKNOWN + N_STALL + N_RANDOM + 2;
    localparam int WATCHDOG_NS = (N_TOTAL + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    rstn;
    logic                    stall;
    logic [`MIPS_XLEN-1:0]   instruction;
    logic [`MIPS_XLEN-1:0]   pc;
    mips_id_pkg::id_fields_t fields;
    logic [`MIPS_XLEN-1:0]   inst_out;
    mips_id_pkg::id_ctrl_t   ctrl;
    mips_id_pkg::id_alu_t    alu;
    mips_id_pkg::id_target_t targets;

    // Word and PC the stage should hold
    logic [`MIPS_XLEN-1:0] exp_inst;
    logic [`MIPS_XLEN-1:0] exp_pc;
    bit checking = 1'b0;
    int errors   = 0;
    int checks   = 0;

    `include "id_decode_ref.svh"

    id_decode_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .instruction (instruction),
        .pc          (pc),
        .fields      (fields),
        .inst_out    (inst_out),
        .ctrl        (ctrl),
        .alu         (alu),
        .targets     (targets)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Expected stage contents
    //////////////////////////////

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_inst <= '0;
            exp_pc   <= '0;
        end else if (!stall) begin
            exp_inst <= instruction;
            exp_pc   <= pc;
        end
    end

    task automatic flag_error(string what, logic [127:0] got, logic [127:0] exp);
        errors++;
        $display("ERROR t=%0t %s mismatch: got %0h expected %0h", $time, what, got, exp);
    endtask

    task automatic compare_outputs();
        mips_id_pkg::id_ctrl_t   ec;
        mips_id_pkg::id_alu_t    ea;
        mips_id_pkg::id_target_t et;
        ec = ref_ctrl(exp_inst);
        ea = ref_alu(exp_inst);
        et = ref_targets(exp_inst, exp_pc);
        checks++;
        if (inst_out !== exp_inst) flag_error("inst_out", 128'(inst_out), 128'(exp_inst));
        // opcode rs rt rd, then imm and funct
        if (fields !== {exp_inst[31:11], exp_inst[15:0], exp_inst[5:0]})
            flag_error("fields", 128'(fields), 128'(exp_inst));
        if (ctrl !== ec) flag_error("ctrl", 128'(ctrl), 128'(ec));
        if (alu !== ea) flag_error("alu", 128'(alu), 128'(ea));
        if (targets !== et) flag_error("targets", 128'(targets), 128'(et));
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (checking) compare_outputs();
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic send(logic [`MIPS_XLEN-1:0] w, logic [`MIPS_XLEN-1:0] p);
        @(negedge clk);
        instruction = w;
        pc          = p;
    endtask

    function automatic logic [`MIPS_XLEN-1:0] rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    // Three in four words get a kept opcode
    function automatic logic [`MIPS_XLEN-1:0] biased_word();
        mips_id_pkg::opcode_e  op;
        logic [`MIPS_XLEN-1:0] w;
        w = $urandom;
        if ($urandom % 4 != 0) begin
            op = op.first();
            repeat ($urandom % op.num()) op = op.next();
            w[31:26] = op;
        end
        return w;
    endfunction

    initial begin
        mips_id_pkg::funct_e   fn;
        mips_id_pkg::regimm_e  ri;
        mips_id_pkg::opcode_e  op;
        logic [`MIPS_XLEN-1:0] w;
        void'($urandom(SEED));
        rstn        = 1'b0;
        stall       = 1'b0;
        // Nonzero so the cleared register is visible
        instruction = 32'h2408_1234;
        pc          = 32'h0040_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (ctrl !== '0) flag_error("reset ctrl", 128'(ctrl), 128'd0);
        if (inst_out !== '0) flag_error("reset inst_out", 128'(inst_out), 128'd0);
        if (targets.pc_plus_4 !== 32'd4)
            flag_error("reset pc_plus_4", 128'(targets.pc_plus_4), 128'd4);
        if (alu.alu_op !== mips_id_pkg::ALU_SLL)
            flag_error("reset alu_op", 128'(alu.alu_op), 128'(mips_id_pkg::ALU_SLL));
        checking = 1'b1;

        // Every kept funct and REGIMM rt code
        fn = fn.first();
        repeat (fn.num()) begin
            w = $urandom;
            w[31:26] = 6'h00;
            w[5:0]   = fn;
            send(w, rand_pc());
            fn = fn.next();
        end
        ri = ri.first();
        repeat (ri.num()) begin
            w = $urandom;
            w[31:26] = 6'h01;
            w[20:16] = ri;
            send(w, rand_pc());
            ri = ri.next();
        end

        // I-type and J-type, immediate sign alternating
        op = op.first();
        repeat (op.num()) begin
            if (op != mips_id_pkg::OP_SPECIAL && op != mips_id_pkg::OP_REGIMM) begin
                for (int k = 0; k < 4; k++) begin
                    w = $urandom;
                    w[31:26] = op;
                    w[15]    = k[0];
                    send(w, rand_pc());
                end
            end
            op = op.next();
        end

        // NOP word, then full opcode, funct and rt sweeps
        send('0, rand_pc());
        for (int o = 0; o < 64; o++) begin
            w = $urandom;
            w[31:26] = o[5:0];
            send(w, rand_pc());
        end
        for (int f = 0; f < 64; f++) begin
            w = $urandom;
            w[31:26] = 6'h00;
            w[5:0]   = f[5:0];
            send(w, rand_pc());
        end
        for (int r = 0; r < 32; r++) begin
            w = $urandom;
            w[31:26] = 6'h01;
            w[20:16] = r[4:0];
            send(w, rand_pc());
        end

        // Stall toggling over fresh words
        repeat (N_STALL) begin
            send(biased_word(), rand_pc());
            stall = ($urandom % 2) == 1;
        end
        stall = 1'b0;

        repeat (N_RANDOM) send(biased_word(), rand_pc());

        // Let the last word reach the compare
        repeat (2) @(posedge clk);
        checking = 1'b0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: hdl/id_alu_ctrl.sv
// Decode ALU operation and result group
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_alu_ctrl (
    input  mips_id_pkg::id_fields_t fields,
    output mips_id_pkg::id_alu_t    alu
);

    mips_id_pkg::alu_op_e  alu_op;
    mips_id_pkg::alu_sel_e alu_sel;

    //////////////////////////////
    // Operation code
    //////////////////////////////

    always_comb begin
        alu_op = mips_id_pkg::ALU_NOP;
        case (fields.opcode)
            mips_id_pkg::OP_SPECIAL: begin
                case (fields.funct)
                    mips_id_pkg::FN_ADD:     alu_op = mips_id_pkg::ALU_ADD;
                    mips_id_pkg::FN_ADDU:    alu_op = mips_id_pkg::ALU_ADDU;
                    mips_id_pkg::FN_SUB:     alu_op = mips_id_pkg::ALU_SUB;
                    mips_id_pkg::FN_SUBU:    alu_op = mips_id_pkg::ALU_SUBU;
                    mips_id_pkg::FN_SLT:     alu_op = mips_id_pkg::ALU_SLT;
                    mips_id_pkg::FN_SLTU:    alu_op = mips_id_pkg::ALU_SLTU;
                    mips_id_pkg::FN_AND:     alu_op = mips_id_pkg::ALU_AND;
                    mips_id_pkg::FN_OR:      alu_op = mips_id_pkg::ALU_OR;
                    mips_id_pkg::FN_XOR:     alu_op = mips_id_pkg::ALU_XOR;
                    mips_id_pkg::FN_NOR:     alu_op = mips_id_pkg::ALU_NOR;
                    mips_id_pkg::FN_SLL:     alu_op = mips_id_pkg::ALU_SLL;
                    mips_id_pkg::FN_SRL:     alu_op = mips_id_pkg::ALU_SRL;
                    mips_id_pkg::FN_SRA:     alu_op = mips_id_pkg::ALU_SRA;
                    mips_id_pkg::FN_SLLV:    alu_op = mips_id_pkg::ALU_SLLV;
                    mips_id_pkg::FN_SRLV:    alu_op = mips_id_pkg::ALU_SRLV;
                    mips_id_pkg::FN_SRAV:    alu_op = mips_id_pkg::ALU_SRAV;
                    mips_id_pkg::FN_MULT:    alu_op = mips_id_pkg::ALU_MULT;
                    mips_id_pkg::FN_MULTU:   alu_op = mips_id_pkg::ALU_MULTU;
                    mips_id_pkg::FN_DIV:     alu_op = mips_id_pkg::ALU_DIV;
                    mips_id_pkg::FN_DIVU:    alu_op = mips_id_pkg::ALU_DIVU;
                    mips_id_pkg::FN_MFHI:    alu_op = mips_id_pkg::ALU_MFHI;
                    mips_id_pkg::FN_MTHI:    alu_op = mips_id_pkg::ALU_MTHI;
                    mips_id_pkg::FN_MFLO:    alu_op = mips_id_pkg::ALU_MFLO;
                    mips_id_pkg::FN_MTLO:    alu_op = mips_id_pkg::ALU_MTLO;
                    mips_id_pkg::FN_JR:      alu_op = mips_id_pkg::ALU_JR;
                    mips_id_pkg::FN_JALR:    alu_op = mips_id_pkg::ALU_JALR;
                    mips_id_pkg::FN_SYSCALL: alu_op = mips_id_pkg::ALU_SYSCALL;
                    mips_id_pkg::FN_BREAK:   alu_op = mips_id_pkg::ALU_BREAK;
                    default: ;
                endcase
            end
            mips_id_pkg::OP_REGIMM: begin
                case (fields.rt)
                    mips_id_pkg::RI_BLTZ:   alu_op = mips_id_pkg::ALU_BLTZ;
                    mips_id_pkg::RI_BGEZ:   alu_op = mips_id_pkg::ALU_BGEZ;
                    mips_id_pkg::RI_BLTZAL: alu_op = mips_id_pkg::ALU_BLTZAL;
                    mips_id_pkg::RI_BGEZAL: alu_op = mips_id_pkg::ALU_BGEZAL;
                    default: ;
                endcase
            end
            mips_id_pkg::OP_J:     alu_op = mips_id_pkg::ALU_J;
            mips_id_pkg::OP_JAL:   alu_op = mips_id_pkg::ALU_JAL;
            mips_id_pkg::OP_BEQ:   alu_op = mips_id_pkg::ALU_BEQ;
            mips_id_pkg::OP_BNE:   alu_op = mips_id_pkg::ALU_BNE;
            mips_id_pkg::OP_BLEZ:  alu_op = mips_id_pkg::ALU_BLEZ;
            mips_id_pkg::OP_BGTZ:  alu_op = mips_id_pkg::ALU_BGTZ;
            mips_id_pkg::OP_ADDI:  alu_op = mips_id_pkg::ALU_ADDI;
            mips_id_pkg::OP_ADDIU: alu_op = mips_id_pkg::ALU_ADDIU;
            mips_id_pkg::OP_SLTI:  alu_op = mips_id_pkg::ALU_SLTI;
            mips_id_pkg::OP_SLTIU: alu_op = mips_id_pkg::ALU_SLTIU;
            mips_id_pkg::OP_ANDI:  alu_op = mips_id_pkg::ALU_ANDI;
            mips_id_pkg::OP_ORI:   alu_op = mips_id_pkg::ALU_ORI;
            mips_id_pkg::OP_XORI:  alu_op = mips_id_pkg::ALU_XORI;
            mips_id_pkg::OP_LUI:   alu_op = mips_id_pkg::ALU_LUI;
            mips_id_pkg::OP_LB:    alu_op = mips_id_pkg::ALU_LB;
            mips_id_pkg::OP_LBU:   alu_op = mips_id_pkg::ALU_LBU;
            mips_id_pkg::OP_LH:    alu_op = mips_id_pkg::ALU_LH;
            mips_id_pkg::OP_LHU:   alu_op = mips_id_pkg::ALU_LHU;
            mips_id_pkg::OP_LW:    alu_op = mips_id_pkg::ALU_LW;
            mips_id_pkg::OP_SB:    alu_op = mips_id_pkg::ALU_SB;
            mips_id_pkg::OP_SH:    alu_op = mips_id_pkg::ALU_SH;
            mips_id_pkg::OP_SW:    alu_op = mips_id_pkg::ALU_SW;
            default: ;
        endcase
    end

    //////////////////////////////
    // Result group
    //////////////////////////////

    // Branches, jumps and traps fall through to NOP
    always_comb begin
        alu_sel = mips_id_pkg::SEL_NOP;
        case (fields.opcode)
            mips_id_pkg::OP_SPECIAL: begin
                case (fields.funct)
                    mips_id_pkg::FN_ADD, mips_id_pkg::FN_ADDU, mips_id_pkg::FN_SUB,
                    mips_id_pkg::FN_SUBU, mips_id_pkg::FN_SLT, mips_id_pkg::FN_SLTU,
                    mips_id_pkg::FN_MULT, mips_id_pkg::FN_MULTU, mips_id_pkg::FN_DIV,
                    mips_id_pkg::FN_DIVU: alu_sel = mips_id_pkg::SEL_ARITHMETIC;
                    mips_id_pkg::FN_AND, mips_id_pkg::FN_OR, mips_id_pkg::FN_XOR,
                    mips_id_pkg::FN_NOR: alu_sel = mips_id_pkg::SEL_LOGIC;
                    mips_id_pkg::FN_SLL, mips_id_pkg::FN_SRL, mips_id_pkg::FN_SRA,
                    mips_id_pkg::FN_SLLV, mips_id_pkg::FN_SRLV,
                    mips_id_pkg::FN_SRAV: alu_sel = mips_id_pkg::SEL_SHIFT;
                    // HI/LO traffic
                    mips_id_pkg::FN_MFHI, mips_id_pkg::FN_MTHI, mips_id_pkg::FN_MFLO,
                    mips_id_pkg::FN_MTLO: alu_sel = mips_id_pkg::SEL_MOVE;
                    default: ;
                endcase
            end
            mips_id_pkg::OP_ADDI, mips_id_pkg::OP_ADDIU, mips_id_pkg::OP_SLTI,
            mips_id_pkg::OP_SLTIU: alu_sel = mips_id_pkg::SEL_ARITHMETIC;
            mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI, mips_id_pkg::OP_XORI,
            mips_id_pkg::OP_LUI: alu_sel = mips_id_pkg::SEL_LOGIC;
            // Address add for memory ops
            mips_id_pkg::OP_LB, mips_id_pkg::OP_LBU, mips_id_pkg::OP_LH,
            mips_id_pkg::OP_LHU, mips_id_pkg::OP_LW, mips_id_pkg::OP_SB,
            mips_id_pkg::OP_SH, mips_id_pkg::OP_SW: alu_sel = mips_id_pkg::SEL_LOAD_STORE;
            default: ;
        endcase
    end

    assign alu = '{alu_op: alu_op, alu_sel: alu_sel};

    // Op and group tables must agree on unknowns
    a_nop_group: assert property (
        @(alu) (alu.alu_op == mips_id_pkg::ALU_NOP) |-> (alu.alu_sel == mips_id_pkg::SEL_NOP)
    ) else $error("ALU NOP with non-NOP group");

endmodule

// File: hdl/id_decode_top.sv
// Instruction decode stage top
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_decode_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    stall,
    input  logic [`MIPS_XLEN-1:0]   instruction,
    input  logic [`MIPS_XLEN-1:0]   pc,
    output mips_id_pkg::id_fields_t fields,
    output logic [`MIPS_XLEN-1:0]   inst_out,
    output mips_id_pkg::id_ctrl_t   ctrl,
    output mips_id_pkg::id_alu_t    alu,
    output mips_id_pkg::id_target_t targets
);

    // Latched PC, only the target unit needs it
    logic [`MIPS_XLEN-1:0] pc_q;

    //////////////////////////////
    // Stage register
    //////////////////////////////

    id_stage_reg u_stage_reg (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .instruction (instruction),
        .pc          (pc),
        .inst_q      (inst_out),
        .pc_q        (pc_q),
        .fields      (fields)
    );

    //////////////////////////////
    // Combinational decode
    //////////////////////////////

    id_main_ctrl u_main_ctrl (
        .inst_q (inst_out),
        .fields (fields),
        .ctrl   (ctrl)
    );

    id_alu_ctrl u_alu_ctrl (
        .fields (fields),
        .alu    (alu)
    );

    id_target_gen u_target_gen (
        .fields  (fields),
        .inst_q  (inst_out),
        .pc_q    (pc_q),
        .targets (targets)
    );

endmodule

// File: hdl/id_main_ctrl.sv
// Decode control flags
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_main_ctrl (
    input  logic [`MIPS_XLEN-1:0]   inst_q,
    input  mips_id_pkg::id_fields_t fields,
    output mips_id_pkg::id_ctrl_t   ctrl
);

    always_comb begin
        ctrl = '0;
        // All-zero word is the canonical NOP, not SLL
        if (inst_q != '0) begin
            case (fields.opcode)
                //////////////////////////////
                // R-type, by funct
                //////////////////////////////
                mips_id_pkg::OP_SPECIAL: begin
                    case (fields.funct)
                        mips_id_pkg::FN_ADD, mips_id_pkg::FN_ADDU,
                        mips_id_pkg::FN_SUB, mips_id_pkg::FN_SUBU,
                        mips_id_pkg::FN_SLT, mips_id_pkg::FN_SLTU,
                        mips_id_pkg::FN_AND, mips_id_pkg::FN_OR,
                        mips_id_pkg::FN_XOR, mips_id_pkg::FN_NOR,
                        mips_id_pkg::FN_SLL, mips_id_pkg::FN_SRL,
                        mips_id_pkg::FN_SRA, mips_id_pkg::FN_SLLV,
                        mips_id_pkg::FN_SRLV, mips_id_pkg::FN_SRAV,
                        mips_id_pkg::FN_MULT, mips_id_pkg::FN_MULTU,
                        mips_id_pkg::FN_DIV, mips_id_pkg::FN_DIVU,
                        mips_id_pkg::FN_MFHI, mips_id_pkg::FN_MFLO: begin
                            ctrl.reg_dst   = 1'b1;
                            ctrl.reg_write = 1'b1;
                        end
                        // Link into rd
                        mips_id_pkg::FN_JALR: begin
                            ctrl.reg_dst   = 1'b1;
                            ctrl.reg_write = 1'b1;
                            ctrl.jump      = 1'b1;
                        end
                        mips_id_pkg::FN_JR: begin
                            ctrl.reg_dst = 1'b1;
                            ctrl.jump    = 1'b1;
                        end
                        // No GPR result
                        mips_id_pkg::FN_MTHI, mips_id_pkg::FN_MTLO,
                        mips_id_pkg::FN_SYSCALL, mips_id_pkg::FN_BREAK: begin
                            ctrl.reg_dst = 1'b1;
                        end
                        default: ;
                    endcase
                end

                // REGIMM branches keyed by rt
                mips_id_pkg::OP_REGIMM: begin
                    case (fields.rt)
                        mips_id_pkg::RI_BLTZ, mips_id_pkg::RI_BGEZ: begin
                            ctrl.branch = 1'b1;
                        end
                        // Writes $ra
                        mips_id_pkg::RI_BLTZAL, mips_id_pkg::RI_BGEZAL: begin
                            ctrl.branch    = 1'b1;
                            ctrl.reg_write = 1'b1;
                        end
                        default: ;
                    endcase
                end

                //////////////////////////////
                // I-type and J-type
                //////////////////////////////
                mips_id_pkg::OP_J: ctrl.jump = 1'b1;
                mips_id_pkg::OP_JAL: begin
                    ctrl.jump      = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                mips_id_pkg::OP_BEQ, mips_id_pkg::OP_BNE,
                mips_id_pkg::OP_BLEZ, mips_id_pkg::OP_BGTZ: ctrl.branch = 1'b1;
                mips_id_pkg::OP_ADDI, mips_id_pkg::OP_ADDIU,
                mips_id_pkg::OP_SLTI, mips_id_pkg::OP_SLTIU,
                mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI,
                mips_id_pkg::OP_XORI, mips_id_pkg::OP_LUI: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                // Loads write rt from memory
                mips_id_pkg::OP_LB, mips_id_pkg::OP_LBU, mips_id_pkg::OP_LH,
                mips_id_pkg::OP_LHU, mips_id_pkg::OP_LW: begin
                    ctrl.alu_src    = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end
                mips_id_pkg::OP_SB, mips_id_pkg::OP_SH, mips_id_pkg::OP_SW: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // One memory access kind per instruction
    a_mem_excl: assert property (
        @(ctrl) !(ctrl.mem_read && ctrl.mem_write)
    ) else $error("mem_read and mem_write both set");

endmodule

// File: hdl/id_stage_reg.sv
// Decode stage register
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_stage_reg (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  logic [`MIPS_XLEN-1:0]  instruction,
    input  logic [`MIPS_XLEN-1:0]  pc,
    output logic [`MIPS_XLEN-1:0]  inst_q,
    output logic [`MIPS_XLEN-1:0]  pc_q,
    output mips_id_pkg::id_fields_t fields
);

    // Word and PC move together so every output refers to one instruction
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (!stall) begin
            inst_q <= instruction;
            pc_q   <= pc;
        end
    end

    //////////////////////////////
    // Field split
    //////////////////////////////

    always_comb begin
        fields.opcode = mips_id_pkg::opcode_e'(inst_q[31:26]);
        fields.rs     = inst_q[25:21];
        fields.rt     = inst_q[20:16];
        fields.rd     = inst_q[15:11];
        fields.imm    = inst_q[15:0];
        // shamt in 10:6 is left to execute
        fields.funct  = mips_id_pkg::funct_e'(inst_q[5:0]);
    end

    // Held word across a stall
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rstn) stall |=> $stable(inst_q)
    ) else $error("inst_q changed during stall");

endmodule

// File: hdl/id_target_gen.sv
// Immediate and next-PC targets
`timescale 1ns/10ps
`include "mips_id_settings.svh"

module id_target_gen (
    input  mips_id_pkg::id_fields_t fields,
    input  logic [`MIPS_XLEN-1:0]   inst_q,
    input  logic [`MIPS_XLEN-1:0]   pc_q,
    output mips_id_pkg::id_target_t targets
);

    localparam int EXT_W = `MIPS_XLEN - `MIPS_IMM_W;

    logic                  zero_ext;
    logic [`MIPS_XLEN-1:0] ext_imm;
    logic [`MIPS_XLEN-1:0] pc_plus_4;

    // Logical immediates are unsigned
    always_comb begin
        case (fields.opcode)
            mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI,
            mips_id_pkg::OP_XORI, mips_id_pkg::OP_LUI: zero_ext = 1'b1;
            default: zero_ext = 1'b0;
        endcase
    end

    assign ext_imm = zero_ext ? {{EXT_W{1'b0}}, fields.imm}
                              : {{EXT_W{fields.imm[`MIPS_IMM_W-1]}}, fields.imm};

    assign pc_plus_4 = pc_q + `MIPS_XLEN'(`MIPS_PC_STEP);

    //////////////////////////////
    // Target bundle
    //////////////////////////////

    always_comb begin
        targets.extended_imm = ext_imm;
        targets.pc_plus_4    = pc_plus_4;
        // Word offset from the delay slot
        targets.pc_branch    = pc_plus_4 + {ext_imm[`MIPS_XLEN-3:0], 2'b00};
        // Region bits come from the delay slot address
        targets.pc_jump      = {pc_plus_4[`MIPS_XLEN-1:`MIPS_XLEN-4],
                                inst_q[`MIPS_JIDX_W-1:0], 2'b00};
    end

endmodule

// File: hdl/mips_id_pkg.sv
// MIPS decode stage types
`include "mips_id_settings.svh"

package mips_id_pkg;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    // Primary opcode, bits 31:26
    typedef enum logic [`MIPS_OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
    } opcode_e;

    // SPECIAL function field, bits 5:0
    typedef enum logic [`MIPS_FUNCT_W-1:0] {
        FN_SLL   = 6'h00, FN_SRL     = 6'h02, FN_SRA   = 6'h03, FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06, FN_SRAV    = 6'h07, FN_JR    = 6'h08, FN_JALR  = 6'h09,
        FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_MFHI  = 6'h10, FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12, FN_MTLO    = 6'h13, FN_MULT  = 6'h18, FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a, FN_DIVU    = 6'h1b, FN_ADD   = 6'h20, FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22, FN_SUBU    = 6'h23, FN_AND   = 6'h24, FN_OR    = 6'h25,
        FN_XOR   = 6'h26, FN_NOR     = 6'h27, FN_SLT   = 6'h2a, FN_SLTU  = 6'h2b
    } funct_e;

    // REGIMM branch kind, carried in rt
    typedef enum logic [`MIPS_REG_ADDR_W-1:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    //////////////////////////////
    // ALU control codes
    //////////////////////////////

    // High nibble follows the result group
    typedef enum logic [`MIPS_ALU_OP_W-1:0] {
        ALU_NOP    = 8'h00,
        ALU_AND    = 8'h01, ALU_OR     = 8'h02, ALU_XOR    = 8'h03, ALU_NOR   = 8'h04,
        ALU_ANDI   = 8'h05, ALU_ORI    = 8'h06, ALU_XORI   = 8'h07, ALU_LUI   = 8'h08,
        ALU_SLL    = 8'h10, ALU_SRL    = 8'h11, ALU_SRA    = 8'h12, ALU_SLLV  = 8'h13,
        ALU_SRLV   = 8'h14, ALU_SRAV   = 8'h15,
        ALU_MFHI   = 8'h20, ALU_MTHI   = 8'h21, ALU_MFLO   = 8'h22, ALU_MTLO  = 8'h23,
        ALU_ADD    = 8'h30, ALU_ADDU   = 8'h31, ALU_SUB    = 8'h32, ALU_SUBU  = 8'h33,
        ALU_SLT    = 8'h34, ALU_SLTU   = 8'h35, ALU_ADDI   = 8'h36, ALU_ADDIU = 8'h37,
        ALU_SLTI   = 8'h38, ALU_SLTIU  = 8'h39, ALU_MULT   = 8'h3a, ALU_MULTU = 8'h3b,
        ALU_DIV    = 8'h3c, ALU_DIVU   = 8'h3d,
        ALU_J      = 8'h40, ALU_JAL    = 8'h41, ALU_JR     = 8'h42, ALU_JALR  = 8'h43,
        ALU_BEQ    = 8'h44, ALU_BNE    = 8'h45, ALU_BGTZ   = 8'h46, ALU_BLEZ  = 8'h47,
        ALU_BGEZ   = 8'h48, ALU_BLTZ   = 8'h49, ALU_BGEZAL = 8'h4a, ALU_BLTZAL = 8'h4b,
        ALU_LB     = 8'h50, ALU_LBU    = 8'h51, ALU_LH     = 8'h52, ALU_LHU   = 8'h53,
        ALU_LW     = 8'h54, ALU_SB     = 8'h55, ALU_SH     = 8'h56, ALU_SW    = 8'h57,
        ALU_SYSCALL = 8'h60, ALU_BREAK = 8'h61
    } alu_op_e;

    // Result mux select in execute
    typedef enum logic [`MIPS_ALU_SEL_W-1:0] {
        SEL_NOP        = 3'd0,
        SEL_LOGIC      = 3'd1,
        SEL_SHIFT      = 3'd2,
        SEL_MOVE       = 3'd3,
        SEL_ARITHMETIC = 3'd4,
        SEL_LOAD_STORE = 3'd5
    } alu_sel_e;

    //////////////////////////////
    // Port bundles
    //////////////////////////////

    // Latched word split into its fields
    typedef struct packed {
        opcode_e                     opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [`MIPS_IMM_W-1:0]      imm;
        funct_e                      funct;
    } id_fields_t;

    // Datapath control flags
    typedef struct packed {
        logic alu_src;
        logic reg_dst;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic branch;
        logic jump;
    } id_ctrl_t;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_sel_e alu_sel;
    } id_alu_t;

    // Immediate and next-PC candidates
    typedef struct packed {
        logic [`MIPS_XLEN-1:0] extended_imm;
        logic [`MIPS_XLEN-1:0] pc_plus_4;
        logic [`MIPS_XLEN-1:0] pc_branch;
        logic [`MIPS_XLEN-1:0] pc_jump;
    } id_target_t;

endpackage

// File: hdl/mips_id_settings.svh
// MIPS decode stage settings
`ifndef MIPS_ID_SETTINGS_SVH
`define MIPS_ID_SETTINGS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data and address width
`define MIPS_XLEN 32
// Register file address
`define MIPS_REG_ADDR_W 5

//////////////////////////////
// Instruction word fields
//////////////////////////////

`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6
`define MIPS_IMM_W 16
// J-type index, shifted left by two in the target
`define MIPS_JIDX_W 26

//////////////////////////////
// ALU control and PC
//////////////////////////////

`define MIPS_ALU_OP_W 8
`define MIPS_ALU_SEL_W 3
// Byte step between sequential instructions
`define MIPS_PC_STEP 4

`endif

// File: mips_id.f
+incdir+hdl
+incdir+dv
hdl/mips_id_pkg.sv
hdl/id_stage_reg.sv
hdl/id_main_ctrl.sv
hdl/id_alu_ctrl.sv
hdl/id_target_gen.sv
hdl/id_decode_top.sv
dv/id_decode_tb.sv
